//--- pm_isa_pkg.sv
`default_nettype none

package pm_isa_pkg;

	// counter widths
	localparam int lg_w = 2;
	localparam int lk_w = 4;
	localparam int mc_w = 2;

	// opcodes decoded by the model
	localparam logic [5:0] op_lw  = 6'o20;
	localparam logic [5:0] op_grp = 6'o31;
	localparam logic [5:0] op_md  = 6'o56;
	localparam logic [5:0] op_shc = 6'o73;

	// instruction word, op in the top six bits
	typedef struct packed {
		logic [5:0] op;
		logic       d;
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
	} pm_instr_t;

	// bit 2 marks an opcode outside the four classes
	typedef enum logic [2:0] {
		oc_md  = 3'b000,
		oc_lw  = 3'b001,
		oc_shc = 3'b010,
		oc_grp = 3'b011,
		oc_ill = 3'b100
	} pm_opclass_t;

	typedef enum logic [2:0] {
		st_p0 = 3'd0,
		st_p1 = 3'd1,
		st_p2 = 3'd2,
		st_p3 = 3'd3,
		st_p4 = 3'd4,
		st_p5 = 3'd5,
		st_i  = 3'd6
	} pm_state_t;

	function automatic pm_opclass_t op_class(input logic [5:0] op);
		case (op)
			op_md:   op_class = oc_md;
			op_lw:   op_class = oc_lw;
			op_shc:  op_class = oc_shc;
			op_grp:  op_class = oc_grp;
			default: op_class = oc_ill;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- pm_bus_pkg.sv
`default_nettype none

package pm_bus_pkg;

	// register offsets on the control port
	localparam logic [3:0] addr_ir     = 4'h0;
	localparam logic [3:0] addr_ctl    = 4'h4;
	localparam logic [3:0] addr_status = 4'h8;

	// master to slave
	typedef struct packed {
		logic [3:0]  awaddr;
		logic        awvalid;
		logic [15:0] wdata;
		logic        wvalid;
		logic        bready;
		logic [3:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [15:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	// one word per state cycle
	typedef struct packed {
		pm_isa_pkg::pm_state_t        state;
		logic                         w_ic;
		logic                         w_ac;
		logic                         w_ar;
		logic                         w_r;
		logic [2:0]                   rsel;
		logic [pm_isa_pkg::lg_w-1:0]  lg;
		logic [pm_isa_pkg::lk_w-1:0]  lk;
	} pm_uop_t;

	// run sits in bit 0
	typedef struct packed {
		logic [6:0]                  rsvd;
		pm_isa_pkg::pm_opclass_t     opclass;
		logic [pm_isa_pkg::mc_w-1:0] mc;
		logic                        int_taken;
		logic                        illegal;
		logic                        busy;
		logic                        run;
	} pm_status_t;

endpackage

`default_nettype wire

//--- pm_panel_regs.sv
`default_nettype none

module pm_panel_regs (
	input  wire                              __clk,
	input  wire                              rst_n,
	input  wire pm_bus_pkg::axil_req_t       req,
	output pm_bus_pkg::axil_rsp_t            rsp,
	input  wire                              busy,
	input  wire                              run,
	input  wire                              int_taken,
	input  wire                              illegal,
	input  wire [pm_isa_pkg::mc_w-1:0]       mc,
	output pm_isa_pkg::pm_instr_t            ir,
	output logic                             ir_load,
	output logic                             start_cmd,
	output logic                             stop_cmd
);
	import pm_isa_pkg::*;
	import pm_bus_pkg::*;

	logic        aw_held;
	logic        w_held;
	logic [3:0]  aw_addr_q;
	logic [15:0] w_data_q;
	logic [3:0]  wr_addr;
	logic [15:0] wr_data;
	logic        awready;
	logic        wready;
	logic        arready;
	logic        aw_fire;
	logic        w_fire;
	logic        ar_fire;
	logic        wr_do;
	logic        ir_refused;
	logic        bvalid;
	logic        rvalid;
	logic [15:0] rdata;
	logic        int_flag;
	pm_status_t  status;

	// the panel only loads an instruction into an idle, running unit
	assign ir_refused = (req.awaddr == addr_ir) && (busy || !run);

	// one response in flight per channel
	assign awready = !aw_held && !bvalid && !ir_refused;
	assign wready  = !w_held && !bvalid;
	assign arready = !rvalid;

	assign aw_fire = req.awvalid && awready;
	assign w_fire  = req.wvalid && wready;
	assign ar_fire = req.arvalid && arready;

	assign wr_addr = aw_held ? aw_addr_q : req.awaddr;
	assign wr_data = w_held ? w_data_q : req.wdata;
	assign wr_do   = (aw_held || aw_fire) && (w_held || w_fire);

	always_comb begin
		rsp         = '0;
		rsp.awready = awready;
		rsp.wready  = wready;
		rsp.bvalid  = bvalid;
		rsp.arready = arready;
		rsp.rdata   = rdata;
		rsp.rvalid  = rvalid;
	end

	always_comb begin
		status           = '0;
		status.run       = run;
		status.busy      = busy;
		status.illegal   = illegal;
		status.int_taken = int_flag;
		status.mc        = mc;
		status.opclass   = op_class(ir.op);
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held   <= 1'b0;
			w_held    <= 1'b0;
			bvalid    <= 1'b0;
			ir        <= '0;
			ir_load   <= 1'b0;
			start_cmd <= 1'b0;
			stop_cmd  <= 1'b0;
		end else begin
			ir_load   <= 1'b0;
			start_cmd <= 1'b0;
			stop_cmd  <= 1'b0;
			if (bvalid && req.bready)
				bvalid <= 1'b0;
			if (wr_do) begin
				bvalid  <= 1'b1;
				aw_held <= 1'b0;
				w_held  <= 1'b0;
				case (wr_addr)
					addr_ir: begin
						ir      <= pm_instr_t'(wr_data);
						ir_load <= 1'b1;
					end
					addr_ctl: begin
						start_cmd <= wr_data[0];
						stop_cmd  <= wr_data[1];
					end
					default: ;
				endcase
			end else begin
				if (aw_fire)
					aw_held <= 1'b1;
				if (w_fire)
					w_held <= 1'b1;
			end
		end
	end

	// read side
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rvalid && req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge __clk) begin
		if (aw_fire)
			aw_addr_q <= req.awaddr;
		if (w_fire)
			w_data_q <= req.wdata;
		if (ar_fire) begin
			case (req.araddr)
				addr_ir:     rdata <= ir;
				addr_ctl:    rdata <= {15'd0, run};
				addr_status: rdata <= status;
				default:     rdata <= '0;
			endcase
		end
	end

	// interrupt seen, kept until the next instruction load
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n)
			int_flag <= 1'b0;
		else if (ir_load)
			int_flag <= 1'b0;
		else if (int_taken)
			int_flag <= 1'b1;
	end

endmodule

`default_nettype wire

//--- pm_cycle_ctl.sv
`default_nettype none

module pm_cycle_ctl (
	input  wire                        __clk,
	input  wire                        rst_n,
	input  wire                        start_cmd,
	input  wire                        stop_cmd,
	input  wire                        ir_load,
	input  wire                        instr_done,
	input  wire                        irq,
	input  wire [pm_isa_pkg::mc_w-1:0] mc,
	output logic                       run,
	output logic                       cycle_go,
	output logic                       int_take
);

	logic start_ff;
	logic wait_ff;
	logic stop_pend;
	logic in_instr;
	logic stop_now;

	assign run      = start_ff && !wait_ff;
	assign cycle_go = ir_load && run;

	// stop lands at instruction end, or at once when nothing runs
	assign stop_now = (stop_pend || stop_cmd) && (instr_done || (!in_instr && !cycle_go));

	// no interrupt while a premodification is outstanding
	assign int_take = irq && (mc == '0);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			start_ff  <= 1'b0;
			wait_ff   <= 1'b0;
			stop_pend <= 1'b0;
			in_instr  <= 1'b0;
		end else begin
			if (start_cmd) begin
				start_ff <= 1'b1;
				wait_ff  <= 1'b0;
			end else if (stop_now) begin
				wait_ff <= 1'b1;
			end

			if (stop_now && !start_cmd)
				stop_pend <= 1'b0;
			else if (stop_cmd)
				stop_pend <= 1'b1;

			if (cycle_go)
				in_instr <= 1'b1;
			else if (instr_done)
				in_instr <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- pm_state_seq.sv
`default_nettype none

module pm_state_seq (
	input  wire                         __clk,
	input  wire                         rst_n,
	input  wire                         cycle_go,
	input  wire                         int_take,
	input  wire                         exec_last,
	input  wire pm_isa_pkg::pm_instr_t  ir,
	output pm_isa_pkg::pm_state_t       state,
	output logic                        exec_first,
	output logic                        instr_done,
	output logic [pm_isa_pkg::mc_w-1:0] mc
);
	import pm_isa_pkg::*;

	// pending indicators {argument fetch, B-mod, premod}
	logic [2:0] mods_q;
	logic [2:0] mods;
	logic [2:0] used;
	pm_state_t  state_next;

	// in P1 the fields are decoded straight from the instruction
	assign mods = (state == st_p1) ? {ir.c == 3'd0, ir.b != 3'd0, ir.d} : mods_q;

	always_comb begin
		state_next = state;
		case (state)
			st_p0: begin
				if (cycle_go)
					state_next = st_p1;
			end
			st_p1, st_p2, st_p3, st_p4: begin
				if (mods[2])
					state_next = st_p2;
				else if (mods[1])
					state_next = st_p3;
				else if (mods[0])
					state_next = st_p4;
				else
					state_next = st_i;
			end
			st_i: begin
				if (exec_last)
					state_next = int_take ? st_p5 : st_p0;
			end
			default: state_next = st_p0;
		endcase
	end

	// indicator consumed by the state being entered
	always_comb begin
		case (state_next)
			st_p2:   used = 3'b100;
			st_p3:   used = 3'b010;
			st_p4:   used = 3'b001;
			default: used = 3'b000;
		endcase
	end

	assign exec_first = (state != st_i) && (state_next == st_i);
	assign instr_done = (state != st_p0) && (state_next == st_p0);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= st_p0;
			mods_q <= 3'b000;
		end else begin
			state  <= state_next;
			mods_q <= mods & ~used;
		end
	end

	// premodification counter, saturating
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			mc <= '0;
		end else if (state == st_p1) begin
			if (op_class(ir.op) == oc_md)
				mc <= (mc == '1) ? mc : mc + mc_w'(1);
			else
				mc <= '0;
		end
	end

endmodule

`default_nettype wire

//--- pm_counters.sv
`default_nettype none

module pm_counters (
	input  wire                         __clk,
	input  wire                         rst_n,
	input  wire pm_isa_pkg::pm_instr_t  ir,
	input  wire pm_isa_pkg::pm_state_t  state,
	input  wire                         exec_first,
	output logic [pm_isa_pkg::lg_w-1:0] lg,
	output logic [pm_isa_pkg::lk_w-1:0] lk,
	output logic                        exec_last
);
	import pm_isa_pkg::*;

	pm_opclass_t oc;
	logic        in_exec;

	assign oc      = op_class(ir.op);
	assign in_exec = (state == st_i);

	// shifts run until lk hits zero, groups until the fourth register
	always_comb begin
		case (oc)
			oc_shc:  exec_last = in_exec && (lk == '0);
			oc_grp:  exec_last = in_exec && (lg == '1);
			default: exec_last = in_exec;
		endcase
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			lg <= '0;
			lk <= '0;
		end else if (exec_first) begin
			lg <= '0;
			lk <= (oc == oc_shc) ? ir[lk_w-1:0] : '0;
		end else if (in_exec && !exec_last) begin
			if (oc == oc_shc)
				lk <= lk - lk_w'(1);
			if (oc == oc_grp)
				lg <= lg + lg_w'(1);
		end
	end

endmodule

`default_nettype wire

//--- pm_bus_ctl.sv
`default_nettype none

module pm_bus_ctl (
	input  wire pm_isa_pkg::pm_state_t  state,
	input  wire pm_isa_pkg::pm_instr_t  ir,
	input  wire [pm_isa_pkg::lg_w-1:0]  lg,
	input  wire [pm_isa_pkg::lk_w-1:0]  lk,
	output pm_bus_pkg::pm_uop_t         uop
);
	import pm_isa_pkg::*;

	pm_opclass_t oc;

	assign oc = op_class(ir.op);

	always_comb begin
		uop       = '0;
		uop.state = state;
		case (state)
			st_p1: uop.w_ic = 1'b1;
			st_p2: uop.w_ac = 1'b1;
			st_p3: begin
				uop.w_ar = 1'b1;
				uop.rsel = ir.b;
			end
			st_p4: begin
				uop.w_ar = 1'b1;
				uop.rsel = ir.a;
			end
			// interrupt receive loads both IC and AR
			st_p5: begin
				uop.w_ic = 1'b1;
				uop.w_ar = 1'b1;
			end
			st_i: begin
				uop.w_r = (oc == oc_lw) || (oc == oc_shc) || (oc == oc_grp);
				// group transfer walks registers by the group counter
				uop.rsel = (oc == oc_grp) ? {1'b0, lg} : ir.a;
				uop.lg   = lg;
				uop.lk   = lk;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- pm_top.sv
`default_nettype none

module pm_top (
	input  wire                        __clk,
	input  wire                        rst_n,
	input  wire pm_bus_pkg::axil_req_t req,
	output pm_bus_pkg::axil_rsp_t      rsp,
	input  wire                        irq,
	output pm_bus_pkg::pm_uop_t        uop,
	output logic                       uop_valid
);
	import pm_isa_pkg::*;

	pm_instr_t         ir;
	pm_state_t         state;
	logic              ir_load;
	logic              start_cmd;
	logic              stop_cmd;
	logic              busy;
	logic              run;
	logic              int_entry;
	logic              illegal;
	logic              cycle_go;
	logic              int_take;
	logic              exec_first;
	logic              exec_last;
	logic              instr_done;
	logic [mc_w-1:0]   mc;
	logic [lg_w-1:0]   lg;
	logic [lk_w-1:0]   lk;

	assign busy      = ir_load || (state != st_p0);
	assign uop_valid = (state != st_p0);
	assign int_entry = (state == st_p5);
	assign illegal   = (op_class(ir.op) == oc_ill);

	pm_panel_regs u_panel (
		.__clk     (__clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.busy      (busy),
		.run       (run),
		.int_taken (int_entry),
		.illegal   (illegal),
		.mc        (mc),
		.ir        (ir),
		.ir_load   (ir_load),
		.start_cmd (start_cmd),
		.stop_cmd  (stop_cmd)
	);

	pm_cycle_ctl u_cycle (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.start_cmd  (start_cmd),
		.stop_cmd   (stop_cmd),
		.ir_load    (ir_load),
		.instr_done (instr_done),
		.irq        (irq),
		.mc         (mc),
		.run        (run),
		.cycle_go   (cycle_go),
		.int_take   (int_take)
	);

	pm_state_seq u_seq (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.cycle_go   (cycle_go),
		.int_take   (int_take),
		.exec_last  (exec_last),
		.ir         (ir),
		.state      (state),
		.exec_first (exec_first),
		.instr_done (instr_done),
		.mc         (mc)
	);

	pm_counters u_cnt (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.ir         (ir),
		.state      (state),
		.exec_first (exec_first),
		.lg         (lg),
		.lk         (lk),
		.exec_last  (exec_last)
	);

	pm_bus_ctl u_bus (
		.state (state),
		.ir    (ir),
		.lg    (lg),
		.lk    (lk),
		.uop   (uop)
	);

endmodule

`default_nettype wire

//--- tb_pm_model.svh
`ifndef TB_PM_MODEL_SVH
`define TB_PM_MODEL_SVH

// model state carried from one instruction to the next
logic [mc_w-1:0] mdl_mc;
logic            mdl_int;
logic            mdl_run;
pm_instr_t       mdl_ir;

task automatic report_error(input string msg);
	$display("ERROR: t=%0t %s", $time, msg);
	err_cnt  = err_cnt + 1;
	test_err = test_err + 1;
endtask

task automatic check_uop(input string name, input pm_uop_t got, input pm_uop_t exp);
	if (got !== exp) begin
		$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
		err_cnt  = err_cnt + 1;
		test_err = test_err + 1;
	end
endtask

task automatic check_status(input string name, input pm_status_t got, input pm_status_t exp);
	if (got !== exp) begin
		$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
		err_cnt  = err_cnt + 1;
		test_err = test_err + 1;
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		err_cnt  = err_cnt + 1;
		test_err = test_err + 1;
	end
endtask

function automatic pm_opclass_t classify(input logic [5:0] op);
	if (op == op_md)
		return oc_md;
	if (op == op_lw)
		return oc_lw;
	if (op == op_shc)
		return oc_shc;
	if (op == op_grp)
		return oc_grp;
	return oc_ill;
endfunction

// expected uop list for one instruction, one entry per state cycle
task automatic predict_uops(input pm_instr_t ir, input logic irq_lvl);
	pm_opclass_t oc;
	pm_uop_t     u;
	logic [3:0]  cnt;
	int          n_exec;
	int          k;
	oc  = classify(ir.op);
	cnt = ir[3:0];
	exp_q.delete();
	// counter moves in P1, ahead of the interrupt decision
	if (oc != oc_md)
		mdl_mc = '0;
	else if (mdl_mc != '1)
		mdl_mc = mdl_mc + 1'b1;
	u = '0;
	u.state = st_p1;
	u.w_ic = 1'b1;
	exp_q.push_back(u);
	if (ir.c == 3'd0) begin
		u = '0;
		u.state = st_p2;
		u.w_ac = 1'b1;
		exp_q.push_back(u);
	end
	if (ir.b != 3'd0) begin
		u = '0;
		u.state = st_p3;
		u.w_ar = 1'b1;
		u.rsel = ir.b;
		exp_q.push_back(u);
	end
	if (ir.d) begin
		u = '0;
		u.state = st_p4;
		u.w_ar = 1'b1;
		u.rsel = ir.a;
		exp_q.push_back(u);
	end
	case (oc)
		oc_shc:  n_exec = cnt + 1;
		oc_grp:  n_exec = 4;
		default: n_exec = 1;
	endcase
	for (k = 0; k < n_exec; k++) begin
		u = '0;
		u.state = st_i;
		u.w_r = (oc == oc_lw) || (oc == oc_shc) || (oc == oc_grp);
		u.rsel = ir.a;
		if (oc == oc_grp) begin
			u.lg = k[1:0];
			u.rsel = {1'b0, k[1:0]};
		end
		if (oc == oc_shc)
			u.lk = cnt - k[3:0];
		exp_q.push_back(u);
	end
	mdl_int = irq_lvl && (mdl_mc == '0);
	if (mdl_int) begin
		u = '0;
		u.state = st_p5;
		u.w_ic = 1'b1;
		u.w_ar = 1'b1;
		exp_q.push_back(u);
	end
	mdl_ir = ir;
endtask

function automatic pm_status_t expect_status();
	pm_status_t s;
	s = '0;
	s.run       = mdl_run;
	s.opclass   = classify(mdl_ir.op);
	s.illegal   = (s.opclass == oc_ill);
	s.mc        = mdl_mc;
	s.int_taken = mdl_int;
	return s;
endfunction

task automatic compare_uops();
	int i;
	check_count("uop_count", cap_q.size(), exp_q.size());
	if (cap_q.size() > 0)
		check_count("p1_cycle", first_cyc, load_cyc + 1);
	for (i = 0; i < exp_q.size() && i < cap_q.size(); i++)
		check_uop($sformatf("uop[%0d]", i), cap_q[i], exp_q[i]);
endtask

`endif

//--- tb_pm_top.sv
`default_nettype none

module tb_pm_top;
	import pm_isa_pkg::*;
	import pm_bus_pkg::*;

	localparam int n_basic  = 40;
	localparam int n_long   = 30;
	localparam int n_irq    = 40;
	localparam int n_bp     = 20;
	// the stop test adds one more instruction
	localparam int n_instr  = n_basic + n_long + n_irq + n_bp + 1;
	localparam int wait_max = 200;

	logic      clk;
	logic      rst_n;
	axil_req_t req;
	axil_rsp_t rsp;
	logic      irq;
	pm_uop_t   uop;
	logic      uop_valid;

	int        cyc;
	int        done_cnt;
	int        start_done;
	int        first_cyc;
	int        bresp_cyc;
	int        load_cyc;
	logic      prev_valid;
	pm_uop_t   cap_q[$];
	pm_uop_t   exp_q[$];
	int        err_cnt;
	int        test_err;
	int        n_pass;
	int        n_fail;
	string     cur_test;

	`include "tb_pm_model.svh"

	pm_top UUT (
		.__clk     (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.irq       (irq),
		.uop       (uop),
		.uop_valid (uop_valid)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// uop capture in mid-cycle, where outputs are settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (uop_valid) begin
				if (cap_q.size() == 0)
					first_cyc = cyc;
				cap_q.push_back(uop);
			end
			if (prev_valid && !uop_valid)
				done_cnt = done_cnt + 1;
			prev_valid = uop_valid;
		end
	end

	task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
		logic aw_done;
		logic w_done;
		logic aw_hit;
		logic w_hit;
		logic got;
		int   n;
		int   stall;
		aw_done = 1'b0;
		w_done  = 1'b0;
		got     = 1'b0;
		n       = 0;
		stall   = $urandom % 4;
		@(posedge clk);
		req.awaddr  <= addr;
		req.awvalid <= 1'b1;
		req.wdata   <= data;
		req.wvalid  <= 1'b1;
		req.bready  <= 1'b0;
		while (!(aw_done && w_done) && n < wait_max) begin
			@(negedge clk);
			aw_hit = req.awvalid && rsp.awready;
			w_hit  = req.wvalid && rsp.wready;
			n++;
			@(posedge clk);
			if (aw_hit) begin
				req.awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_hit) begin
				req.wvalid <= 1'b0;
				w_done = 1'b1;
			end
		end
		n = 0;
		while ((aw_done && w_done) && !got && n < wait_max) begin
			@(negedge clk);
			got = rsp.bvalid;
			n++;
		end
		if (!got) begin
			report_error($sformatf("write to address %h got no response", addr));
			req.awvalid <= 1'b0;
			req.wvalid  <= 1'b0;
		end else begin
			bresp_cyc = cyc;
			check_count("bresp", rsp.bresp, 0);
			repeat (stall) begin
				@(negedge clk);
				if (!rsp.bvalid)
					report_error("write response withdrawn before bready");
			end
			@(posedge clk);
			req.bready <= 1'b1;
			@(posedge clk);
			req.bready <= 1'b0;
			@(negedge clk);
			if (rsp.bvalid)
				report_error("write response still valid after its handshake");
		end
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [15:0] data);
		logic hit;
		logic got;
		int   n;
		int   stall;
		hit   = 1'b0;
		got   = 1'b0;
		n     = 0;
		data  = '0;
		stall = $urandom % 4;
		@(posedge clk);
		req.araddr  <= addr;
		req.arvalid <= 1'b1;
		req.rready  <= 1'b0;
		while (!hit && n < wait_max) begin
			@(negedge clk);
			hit = rsp.arready;
			n++;
			@(posedge clk);
		end
		req.arvalid <= 1'b0;
		n = 0;
		while (hit && !got && n < wait_max) begin
			@(negedge clk);
			got = rsp.rvalid;
			n++;
		end
		if (!got) begin
			report_error($sformatf("read of address %h got no response", addr));
		end else begin
			data = rsp.rdata;
			check_count("rresp", rsp.rresp, 0);
			repeat (stall) begin
				@(negedge clk);
				if (!rsp.rvalid || rsp.rdata !== data)
					report_error("read response lost or changed before rready");
			end
			@(posedge clk);
			req.rready <= 1'b1;
			@(posedge clk);
			req.rready <= 1'b0;
			@(negedge clk);
			if (rsp.rvalid)
				report_error("read response still valid after its handshake");
		end
	endtask

	// AW alone, so no write data is left captured in the slave
	task automatic probe_refused();
		int seen;
		seen = 0;
		@(posedge clk);
		cap_q.delete();
		req.awaddr  <= addr_ir;
		req.awvalid <= 1'b1;
		repeat (8) begin
			@(negedge clk);
			if (rsp.awready)
				seen++;
		end
		@(posedge clk);
		req.awvalid <= 1'b0;
		repeat (4) @(posedge clk);
		if (seen != 0)
			report_error("instruction write accepted while the unit is stopped");
		if (cap_q.size() != 0)
			report_error("uop issued without a loaded instruction");
	endtask

	task automatic issue_instr(input pm_instr_t ir, input logic irq_lvl);
		@(posedge clk);
		irq <= irq_lvl;
		start_done = done_cnt;
		cap_q.delete();
		predict_uops(ir, irq_lvl);
		write_reg(addr_ir, ir);
		load_cyc = bresp_cyc;
	endtask

	task automatic finish_instr();
		int n;
		n = 0;
		while (done_cnt == start_done && n < wait_max) begin
			@(posedge clk);
			n++;
		end
		if (done_cnt == start_done)
			report_error("instruction never returned to P0");
		compare_uops();
	endtask

	task automatic check_idle_status();
		logic [15:0] rd;
		read_reg(addr_status, rd);
		check_status("status", rd, expect_status());
	endtask

	function automatic pm_instr_t rand_instr(input pm_opclass_t oc);
		pm_instr_t ir;
		ir.d = $urandom % 2;
		ir.a = $urandom % 8;
		// zero b and c often enough to see P3 and P2 skipped or taken
		ir.b = ($urandom % 3 == 0) ? 3'd0 : 3'($urandom % 8);
		ir.c = ($urandom % 3 == 0) ? 3'd0 : 3'($urandom % 8);
		case (oc)
			oc_md:   ir.op = op_md;
			oc_lw:   ir.op = op_lw;
			oc_shc:  ir.op = op_shc;
			oc_grp:  ir.op = op_grp;
			default: begin
				ir.op = $urandom % 64;
				while (classify(ir.op) != oc_ill)
					ir.op = $urandom % 64;
			end
		endcase
		return ir;
	endfunction

	function automatic pm_opclass_t rand_class();
		case ($urandom % 8)
			0, 1, 2: return oc_md;
			3:       return oc_lw;
			4:       return oc_shc;
			5:       return oc_grp;
			default: return oc_ill;
		endcase
	endfunction

	task automatic begin_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		if (test_err == 0) begin
			$display("test %s: passed", cur_test);
			n_pass++;
		end else begin
			$display("test %s: failed with %0d errors", cur_test, test_err);
			n_fail++;
		end
	endtask

	// watchdog
	initial begin
		#(n_instr * wait_max * 20);
		$display("ERROR: run did not finish within %0d instruction budgets", n_instr);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		logic [15:0] rd;
		pm_instr_t   ir;
		int          i;
		clk        = 1'b0;
		rst_n      = 1'b0;
		req        = '0;
		irq        = 1'b0;
		cyc        = 0;
		done_cnt   = 0;
		prev_valid = 1'b0;
		err_cnt    = 0;
		n_pass     = 0;
		n_fail     = 0;
		mdl_mc     = '0;
		mdl_int    = 1'b0;
		mdl_run    = 1'b0;
		mdl_ir     = '0;
		void'($urandom(32'h09451cba));
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		begin_test("reset_and_refused_load");
		check_idle_status();
		probe_refused();
		write_reg(addr_ctl, 16'h0001);
		mdl_run = 1'b1;
		check_idle_status();
		end_test();

		begin_test("lw_ill_sequences");
		for (i = 0; i < n_basic; i++) begin
			issue_instr(rand_instr(($urandom % 2) ? oc_lw : oc_ill), $urandom % 2);
			finish_instr();
		end
		end_test();

		begin_test("shc_grp_counters");
		for (i = 0; i < n_long; i++) begin
			issue_instr(rand_instr(($urandom % 2) ? oc_shc : oc_grp), $urandom % 2);
			finish_instr();
		end
		end_test();

		begin_test("interrupt_acceptance");
		for (i = 0; i < n_irq; i++) begin
			issue_instr(rand_instr(rand_class()), $urandom % 2);
			finish_instr();
			check_idle_status();
		end
		end_test();

		begin_test("backpressure_and_stop");
		for (i = 0; i < n_bp; i++) begin
			issue_instr(rand_instr(rand_class()), $urandom % 2);
			finish_instr();
			check_idle_status();
			check_idle_status();
			read_reg(addr_ctl, rd);
			check_count("ctl_rdata", rd, 1);
		end
		// longest shift, so the stop lands mid-instruction
		ir = rand_instr(oc_shc);
		ir.b = 3'd1;
		ir.c = 3'd7;
		issue_instr(ir, 1'b0);
		write_reg(addr_ctl, 16'h0002);
		// run holds until the shift ends
		read_reg(addr_ctl, rd);
		check_count("ctl_rdata", rd, 1);
		finish_instr();
		mdl_run = 1'b0;
		check_idle_status();
		probe_refused();
		write_reg(addr_ctl, 16'h0001);
		mdl_run = 1'b1;
		check_idle_status();
		end_test();

		$display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
			n_pass, n_fail, err_cnt);
		if (err_cnt == 0 && n_fail == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- pm_top.f
+incdir+.
pm_isa_pkg.sv
pm_bus_pkg.sv
pm_panel_regs.sv
pm_cycle_ctl.sv
pm_state_seq.sv
pm_counters.sv
pm_bus_ctl.sv
pm_top.sv
tb_pm_top.sv

//--- Bender.yml
package:
  name: pm_top

sources:
  - pm_isa_pkg.sv
  - pm_bus_pkg.sv
  - pm_panel_regs.sv
  - pm_cycle_ctl.sv
  - pm_state_seq.sv
  - pm_counters.sv
  - pm_bus_ctl.sv
  - pm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pm_top.sv
